// File: hw/synth_cmd_pkg.sv
package synth_cmd_pkg;

    localparam int clks_per_bit = 16;  // Short bit period for simulation

    typedef logic [7:0] uart_byte_t;

    typedef enum logic [1:0] {
        wave_tri,
        wave_saw,
        wave_square,
        wave_sine
    } wave_e;

    typedef logic [5:0] note_t;  // 0 to 35, three octaves

    localparam uart_byte_t cmd_noise_on  = "N";
    localparam uart_byte_t cmd_noise_off = "F";
    localparam uart_byte_t cmd_tri       = "T";
    localparam uart_byte_t cmd_saw       = "S";
    localparam uart_byte_t cmd_square    = "Q";
    localparam uart_byte_t cmd_sine      = "W";

    // Note select, digits first and then letters from note 10
    localparam uart_byte_t cmd_digit_lo  = "0";
    localparam uart_byte_t cmd_digit_hi  = "9";
    localparam uart_byte_t cmd_letter_lo = "A";
    localparam uart_byte_t cmd_letter_hi = "Z";

    typedef struct packed {
        wave_e wave;
        logic  noise_en;
        note_t note;
    } voice_cfg_t;

    localparam voice_cfg_t voice_cfg_reset = '{wave: wave_tri, noise_en: 1'b0, note: '0};

endpackage

// File: hw/synth_audio_pkg.sv
package synth_audio_pkg;

    typedef logic [7:0]  sample_t;
    typedef logic [15:0] phase_t;

    localparam int notes_per_octave = 12;

    // Phase step per clock, lowest octave C to B
    localparam phase_t tuning_table [notes_per_octave] = '{
        16'd64,   // C
        16'd68,
        16'd72,   // D
        16'd76,
        16'd81,   // E
        16'd85,   // F
        16'd91,
        16'd96,   // G
        16'd102,
        16'd108,  // A
        16'd114,
        16'd121   // B
    };

    // One sine period in 16 steps, offset binary
    localparam sample_t sine_table [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246,
        8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,
        8'd0,   8'd10,  8'd38,  8'd80
    };

    localparam logic [15:0] lfsr_seed = 16'hACE1;
    localparam logic [15:0] lfsr_taps = 16'hB400;  // Bits 15, 13, 12, 10

    localparam int i2s_word_bits = 16;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import synth_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output uart_byte_t rx_byte,
    output logic       byte_req,
    input  logic       byte_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    typedef logic [$clog2(clks_per_bit)-1:0] bit_cnt_t;

    rx_state_e  state;
    bit_cnt_t   bit_cnt;
    logic [2:0] bit_idx;
    logic       rx_meta;
    logic       rx_sync;
    uart_byte_t shift_reg;
    logic       frame_ok;  // Good stop bit, byte can be offered
    logic       half_bit;
    logic       full_bit;

    assign half_bit = (bit_cnt == bit_cnt_t'(clks_per_bit / 2 - 1));
    assign full_bit = (bit_cnt == bit_cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // Line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            frame_ok <= 1'b0;
        end else begin
            frame_ok <= 1'b0;
            bit_cnt  <= bit_cnt + 1'b1;
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (half_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? st_idle : st_data;  // Glitch, back to idle
                    end
                end
                st_data: begin
                    if (full_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (full_bit) begin
                        frame_ok <= rx_sync && !byte_req;  // Framing error or busy drops it
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && full_bit) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};  // LSB arrives first
        end
        if (frame_ok) begin
            rx_byte <= shift_reg;  // Held until the next good frame
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_req <= 1'b0;
        end else if (frame_ok) begin
            byte_req <= 1'b1;
        end else if (byte_ack) begin
            byte_req <= 1'b0;
        end
    end

endmodule

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import synth_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  uart_byte_t rx_byte,
    input  logic       byte_req,
    output logic       byte_ack,
    output voice_cfg_t voice
);

    voice_cfg_t voice_next;

    // Command letters win over the note letters they overlap
    always_comb begin
        voice_next = voice;
        case (rx_byte)
            cmd_noise_on:  voice_next.noise_en = 1'b1;
            cmd_noise_off: voice_next.noise_en = 1'b0;
            cmd_tri:       voice_next.wave = wave_tri;
            cmd_saw:       voice_next.wave = wave_saw;
            cmd_square:    voice_next.wave = wave_square;
            cmd_sine:      voice_next.wave = wave_sine;
            default: begin
                if (rx_byte inside {[cmd_digit_lo:cmd_digit_hi]}) begin
                    voice_next.note = note_t'(rx_byte - cmd_digit_lo);  // Notes 0 to 9
                end else if (rx_byte inside {[cmd_letter_lo:cmd_letter_hi]}) begin
                    voice_next.note = note_t'(rx_byte - cmd_letter_lo + 8'd10);
                end
            end
        endcase
    end

    // Acknowledge side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_ack <= 1'b0;
            voice    <= voice_cfg_reset;
        end else if (byte_req && !byte_ack) begin
            byte_ack <= 1'b1;
            voice    <= voice_next;  // Applied once per request
        end else if (!byte_req) begin
            byte_ack <= 1'b0;
        end
    end

endmodule

// File: hw/tone_generator.sv
`timescale 1ns/1ps

module tone_generator import synth_cmd_pkg::*; import synth_audio_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  voice_cfg_t voice,
    output sample_t    sample
);

    logic [3:0]  semitone;
    logic [2:0]  octave;
    phase_t      tune_word;
    phase_t      phase;
    logic [15:0] lfsr;
    sample_t     top;
    sample_t     shaped;
    sample_t     mixed;

    always_comb begin
        semitone  = 4'(voice.note % notes_per_octave);
        octave    = 3'(voice.note / notes_per_octave);
        tune_word = tuning_table[semitone] << octave;  // Each octave doubles the step
    end

    assign top = phase[15:8];

    always_comb begin
        case (voice.wave)
            wave_tri: begin
                // Rise over the first half, fold back over the second
                shaped = top[7] ? ~{top[6:0], 1'b0} : {top[6:0], 1'b0};
            end
            wave_saw:    shaped = top;
            wave_square: shaped = top[7] ? 8'd255 : 8'd0;
            wave_sine:   shaped = sine_table[top[7:4]];
            default:     shaped = top;
        endcase
    end

    assign mixed = shaped ^ (voice.noise_en ? lfsr[7:0] : 8'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
            lfsr  <= lfsr_seed;
        end else begin
            phase <= phase + tune_word;
            lfsr  <= {lfsr[14:0], ^(lfsr & lfsr_taps)};  // Free-running noise
        end
    end

    always_ff @(posedge clk) begin
        sample <= mixed;  // One cycle behind the accumulator
    end

endmodule

// File: hw/i2s_transmitter.sv
`timescale 1ns/1ps

module i2s_transmitter import synth_audio_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    typedef logic [$clog2(i2s_word_bits)-1:0] bit_idx_t;

    bit_idx_t                 bit_idx;   // Bit now on sd
    logic [i2s_word_bits-1:0] shift_reg; // Bits still to send
    logic                     word_end;

    assign word_end = (bit_idx == bit_idx_t'(i2s_word_bits - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck       <= 1'b0;
            ws        <= 1'b0;
            sd        <= 1'b0;
            bit_idx   <= '0;
            shift_reg <= '0;
        end else begin
            sck <= ~sck;
            if (sck) begin  // sck falls on this edge
                if (word_end) begin
                    bit_idx   <= '0;
                    ws        <= ~ws;
                    sd        <= sample[7];  // MSB of the new word goes out now
                    shift_reg <= {sample[6:0], sample, 1'b0};
                end else begin
                    bit_idx   <= bit_idx + 1'b1;
                    sd        <= shift_reg[i2s_word_bits-1];
                    shift_reg <= {shift_reg[i2s_word_bits-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: hw/synth_top.sv
`timescale 1ns/1ps

module synth_top import synth_cmd_pkg::*; import synth_audio_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic sck,
    output logic ws,
    output logic sd
);

    uart_byte_t rx_byte;
    logic       byte_req;
    logic       byte_ack;
    voice_cfg_t voice;
    sample_t    sample;

    uart_rx uart_rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .byte_req (byte_req),
        .byte_ack (byte_ack)
    );

    cmd_decoder cmd_decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .byte_req (byte_req),
        .byte_ack (byte_ack),
        .voice    (voice)
    );

    tone_generator tone_generator_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .voice  (voice),
        .sample (sample)
    );

    i2s_transmitter i2s_transmitter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),  // Sampled at each word start
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

// File: test/synth_tb.sv
`timescale 1ns/1ps

module synth_tb import synth_cmd_pkg::*; import synth_audio_pkg::*; ();

    localparam int timeout_cycles = 20000;  // Tests need about 12k cycles

    logic    clk;
    logic    rst_n;
    logic    rx;
    logic    sck;
    logic    ws;
    logic    sd;
    logic    ws_prev;  // ws during the last captured word
    sample_t samples [$];
    int      cycles;

    synth_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic send_bit(input logic value);
        @(negedge clk);
        rx = value;
        repeat (clks_per_bit - 1) @(negedge clk);
    endtask

    // 8N1 frame, LSB first, followed by one idle bit
    task automatic send_frame(input uart_byte_t data, input logic stop_bit);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(data[i]);
        end
        send_bit(stop_bit);
        send_bit(1'b1);
    endtask

    task automatic send_byte(input uart_byte_t data);
        send_frame(data, 1'b1);
    endtask

    task automatic send_bad_frame(input uart_byte_t data);
        send_frame(data, 1'b0);
        repeat (11) send_bit(1'b1);  // Let the receiver settle on the idle line
    endtask

    // First bit is taken on the next rising sck, which must open a new word
    task automatic capture_word(output sample_t value);
        logic [15:0] word;
        @(posedge sck);
        check_value("ws at word start", 32'(ws), 32'(!ws_prev));
        ws_prev = ws;
        word[15] = sd;
        for (int i = 14; i >= 0; i--) begin
            @(posedge sck);
            check_value("ws within word", 32'(ws), 32'(ws_prev));
            word[i] = sd;
        end
        check_value("word upper byte", 32'(word[15:8]), 32'(word[7:0]));
        value = word[7:0];
    endtask

    // Ends on the last bit of a word
    task automatic sync_word();
        @(posedge sck);
        ws_prev = ws;
        while (ws == ws_prev) @(posedge sck);
        ws_prev = ws;
        repeat (i2s_word_bits - 1) @(posedge sck);
    endtask

    task automatic collect(input int count);
        sample_t value;
        samples.delete();
        sync_word();
        repeat (3) capture_word(value);  // New setting reaches the output
        repeat (count) begin
            capture_word(value);
            samples.push_back(value);
        end
    endtask

    // Successive samples are 32 tuning words apart
    task automatic check_saw_step(input int expected);
        sample_t step;
        collect(10);
        for (int i = 1; i < samples.size(); i++) begin
            step = samples[i] - samples[i-1];
            check_value("sawtooth step", 32'(step), expected);
        end
    endtask

    task automatic test_square_sine();
        bit seen_low = 1'b0;
        bit seen_high = 1'b0;
        bit in_table;
        send_byte(cmd_square);
        collect(40);
        foreach (samples[i]) begin
            seen_low  |= (samples[i] == 8'h00);
            seen_high |= (samples[i] == 8'hff);
            if (samples[i] != 8'h00) begin
                check_value("square sample", 32'(samples[i]), 32'hff);
            end
        end
        check_value("square low seen", 32'(seen_low), 1);
        check_value("square high seen", 32'(seen_high), 1);
        send_byte(cmd_sine);
        collect(32);
        foreach (samples[i]) begin
            in_table = 1'b0;
            for (int j = 0; j < 16; j++) begin
                in_table |= (sine_table[j] == samples[i]);
            end
            check_value("sine sample in table", 32'(in_table), 1);
        end
    endtask

    task automatic test_triangle();
        int diff;
        bit turn_ok;
        bit rising = 1'b0;
        bit falling = 1'b0;
        send_byte(cmd_tri);
        send_byte("0");
        collect(40);
        for (int i = 1; i < samples.size(); i++) begin
            diff = int'(samples[i]) - int'(samples[i-1]);
            turn_ok = (samples[i] >= 8'd240 && samples[i-1] >= 8'd240) ||
                      (samples[i] <= 8'd15 && samples[i-1] <= 8'd15);
            rising  |= (diff == 16);
            falling |= (diff == -16);
            if (diff != 16 && diff != -16) begin
                check_value("triangle turnaround", 32'(turn_ok), 1);
            end
        end
        check_value("triangle rising run", 32'(rising), 1);
        check_value("triangle falling run", 32'(falling), 1);
    endtask

    task automatic test_noise();
        bit noisy = 1'b0;
        send_byte(cmd_square);
        send_byte(cmd_noise_on);
        collect(20);
        foreach (samples[i]) begin
            noisy |= (samples[i] != 8'h00 && samples[i] != 8'hff);
        end
        check_value("noise changes square", 32'(noisy), 1);
        send_byte(cmd_noise_off);
        collect(20);
        foreach (samples[i]) begin
            if (samples[i] != 8'h00) begin
                check_value("square after noise off", 32'(samples[i]), 32'hff);
            end
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        rx      = 1'b1;  // Serial line idles high
        ws_prev = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value("sck after reset", 32'(sck), 0);
        check_value("ws after reset", 32'(ws), 0);
        check_value("sd after reset", 32'(sd), 0);
        collect(8);
        test_square_sine();
        send_byte(cmd_saw);
        send_byte("0");
        check_saw_step(8);  // 32 * 64 / 256 for C
        send_byte("C");  // Note 12, one octave up
        check_saw_step(16);
        send_byte("O");  // Note 24
        check_saw_step(32);
        test_triangle();
        test_noise();
        send_byte(cmd_saw);
        send_byte("0");
        check_saw_step(8);
        send_bad_frame("O");  // Would move two octaves if accepted
        send_byte("?");
        check_saw_step(8);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: vlog.f
hw/synth_cmd_pkg.sv
hw/synth_audio_pkg.sv
hw/uart_rx.sv
hw/cmd_decoder.sv
hw/tone_generator.sv
hw/i2s_transmitter.sv
hw/synth_top.sv
test/synth_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module synth_tb -o synth_sim

./obj_dir/synth_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^TEST PASSED$" sim.log
